// ==== common/core_cfg.svh ====
// core configuration: word width, register count, reset pc and nop encoding
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

//////////////////////////////
// datapath
//////////////////////////////

// data and address word width
`define CORE_XLEN 32

// architectural integer registers, x0 included
`define CORE_REG_COUNT 32

//////////////////////////////
// fetch
//////////////////////////////

// address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

// ==== common/core_pkg.sv ====
// shared types for the four-stage integer pipeline
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////

    // one data or address word
    typedef logic [`CORE_XLEN-1:0] xlen_t;

    // architectural register index
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // execute-stage operations, pass_b serves lui
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_t;

    // wishbone fetch master states
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_REQ  = 2'd1,
        FETCH_HOLD = 2'd2
    } fetch_state_t;

    //////////////////////////////
    // stage payloads
    //////////////////////////////

    // fetch to decode
    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fetch_pkt_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        reg_idx_t rd;
        alu_op_t  op;
        xlen_t    opa;
        xlen_t    opb;
        logic     wr_en;
    } decode_pkt_t;

    // execute to writeback
    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
        logic     wr_en;
    } wb_pkt_t;

endpackage

`default_nettype wire

// ==== decode/decoder.sv ====
// instruction decode for the rv32i subset: fields, immediates and alu operation
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire core_pkg::fetch_pkt_t fetch_pkt,
    output core_pkg::reg_idx_t        rs1_idx,
    output core_pkg::reg_idx_t        rs2_idx,
    input  wire core_pkg::xlen_t      rs1_val,
    input  wire core_pkg::xlen_t      rs2_val,
    output core_pkg::decode_pkt_t     decode_pkt
);

    import core_pkg::*;

    xlen_t    inst;
    reg_idx_t rd;
    xlen_t    imm_i;
    xlen_t    imm_u;
    xlen_t    imm;
    alu_op_t  op;
    logic     known;
    logic     use_imm;
    logic     wr;

    // fixed field positions
    assign inst  = fetch_pkt.inst;
    assign rd    = inst[11:7];
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    // unused source fields read x0, so they never stall
    always_comb begin
        op      = ALU_ADD;
        known   = 1'b0;
        use_imm = 1'b0;
        imm     = imm_i;
        rs1_idx = '0;
        rs2_idx = '0;
        case (inst[6:0])
            // register-register, funct7 and funct3 together
            7'b0110011: begin
                rs1_idx = inst[19:15];
                rs2_idx = inst[24:20];
                known   = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    {7'b0000000, 3'b000}: op = ALU_ADD;
                    {7'b0100000, 3'b000}: op = ALU_SUB;
                    {7'b0000000, 3'b111}: op = ALU_AND;
                    {7'b0000000, 3'b110}: op = ALU_OR;
                    {7'b0000000, 3'b100}: op = ALU_XOR;
                    default: begin
                        known   = 1'b0;
                        rs1_idx = '0;
                        rs2_idx = '0;
                    end
                endcase
            end
            // op-imm, addi only
            7'b0010011: begin
                if (inst[14:12] == 3'b000) begin
                    rs1_idx = inst[19:15];
                    known   = 1'b1;
                    use_imm = 1'b1;
                end
            end
            // lui
            7'b0110111: begin
                op      = ALU_PASS_B;
                known   = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: known = 1'b0;
        endcase
    end

    // x0 targets and unknown encodings travel as non-writing bubbles
    assign wr = known && (rd != '0);

    assign decode_pkt = '{
        rd:    wr ? rd : '0,
        op:    op,
        opa:   rs1_val,
        opb:   use_imm ? imm : rs2_val,
        wr_en: wr
    };

endmodule

`default_nettype wire

// ==== decode/hazard_scoreboard.sv ====
// pending-write scoreboard per register, raises the decode stall on read-after-write
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module hazard_scoreboard (
    input  wire                     clk,
    input  wire                     rst,
    input  wire core_pkg::reg_idx_t rs1_idx,
    input  wire core_pkg::reg_idx_t rs2_idx,
    input  wire                     issue_valid,
    input  wire core_pkg::reg_idx_t issue_rd,
    input  wire                     retire_valid,
    input  wire core_pkg::reg_idx_t retire_rd,
    output logic                    stall
);

    // at most two writes in flight per register, execute and writeback
    logic [1:0]                pend_q [`CORE_REG_COUNT];
    logic [`CORE_REG_COUNT-1:0] inc;
    logic [`CORE_REG_COUNT-1:0] dec;
    logic                      rs1_busy;
    logic                      rs2_busy;

    // x0 never has a pending write
    assign rs1_busy = (rs1_idx != '0) && (pend_q[rs1_idx] != 2'd0);
    assign rs2_busy = (rs2_idx != '0) && (pend_q[rs2_idx] != 2'd0);
    assign stall    = issue_valid && (rs1_busy || rs2_busy);

    // one-hot issue and retire strobes
    always_comb begin
        inc = '0;
        dec = '0;
        if (issue_valid && !stall && (issue_rd != '0)) begin
            inc[issue_rd] = 1'b1;
        end
        if (retire_valid && (retire_rd != '0)) begin
            dec[retire_rd] = 1'b1;
        end
    end

    // issue and retire on the same register cancel
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                pend_q[i] <= 2'd0;
            end
        end else begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                if (inc[i] && !dec[i]) begin
                    pend_q[i] <= pend_q[i] + 2'd1;
                end else if (dec[i] && !inc[i]) begin
                    pend_q[i] <= pend_q[i] - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetch/fetch_fsm.sv ====
// instruction fetch over a read-only wishbone classic port, with pc and hold buffer
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module fetch_fsm (
    input  wire                 clk,
    input  wire                 rst,
    output logic                wb_cyc,
    output logic                wb_stb,
    output core_pkg::xlen_t     wb_adr,
    input  wire                 wb_ack,
    input  wire core_pkg::xlen_t wb_dat,
    input  wire                 hold,
    output logic                fetch_valid,
    output core_pkg::fetch_pkt_t fetch_pkt
);

    import core_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    xlen_t        pc_q;
    fetch_pkt_t   buf_q;
    logic         acked;

    // word arrives in the cycle ack is high
    assign acked = (state_q == FETCH_REQ) && wb_ack;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            // one idle cycle between requests
            FETCH_IDLE: state_d = FETCH_REQ;
            FETCH_REQ: begin
                if (wb_ack) begin
                    // decode busy, park the word
                    state_d = hold ? FETCH_HOLD : FETCH_IDLE;
                end
            end
            FETCH_HOLD: begin
                // buffered word taken at this edge
                if (!hold) begin
                    state_d = FETCH_REQ;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_IDLE;
            pc_q    <= `CORE_RESET_PC;
        end else begin
            state_q <= state_d;
            // next word address
            if (acked) begin
                pc_q <= pc_q + xlen_t'(4);
            end
        end
    end

    // one-word hold buffer
    always_ff @(posedge clk) begin
        if (acked && hold) begin
            buf_q <= '{pc: pc_q, inst: wb_dat};
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // cyc and stb rise and fall together
    assign wb_cyc = (state_q == FETCH_REQ);
    assign wb_stb = (state_q == FETCH_REQ);
    assign wb_adr = pc_q;

    // bus word straight through, or the parked one
    assign fetch_valid = acked || (state_q == FETCH_HOLD);
    assign fetch_pkt   = (state_q == FETCH_HOLD) ? buf_q : '{pc: pc_q, inst: wb_dat};

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/core_pkg.sv
rtl/pipe_reg.sv
fetch/fetch_fsm.sv
decode/decoder.sv
decode/hazard_scoreboard.sv
rtl/regfile.sv
rtl/alu.sv
rtl/core_top.sv
tests/core_tb.sv

// ==== rtl/alu.sv ====
// execute stage: integer alu forming the writeback payload
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire core_pkg::decode_pkt_t decode_pkt,
    output core_pkg::wb_pkt_t          wb_pkt
);

    import core_pkg::*;

    xlen_t a;
    xlen_t b;
    xlen_t result;

    // operand b is already rs2 or the immediate
    assign a = decode_pkt.opa;
    assign b = decode_pkt.opb;

    always_comb begin
        case (decode_pkt.op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            // lui, upper immediate as is
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    // destination and write flag pass through
    assign wb_pkt = '{
        rd:    decode_pkt.rd,
        data:  result,
        wr_en: decode_pkt.wr_en
    };

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
// four-stage in-order integer core: fetch, decode, execute and writeback with commit port
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output core_pkg::xlen_t      wb_adr,
    input  wire                  wb_ack,
    input  wire core_pkg::xlen_t wb_dat,
    output logic                 commit_valid,
    output core_pkg::reg_idx_t   commit_rd,
    output core_pkg::xlen_t      commit_data
);

    import core_pkg::*;

    // fetch side
    logic        fetch_valid;
    fetch_pkt_t  fetch_pkt;
    logic        fd_valid;
    fetch_pkt_t  fd_pkt;

    // decode side
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    xlen_t       rs1_val;
    xlen_t       rs2_val;
    decode_pkt_t decode_pkt;
    logic        stall;

    // execute and writeback
    logic        de_valid;
    decode_pkt_t de_pkt;
    wb_pkt_t     ex_pkt;
    logic        ew_valid;
    wb_pkt_t     ew_pkt;

    //////////////////////////////
    // fetch
    //////////////////////////////

    // stall back-pressures the bus master
    fetch_fsm u_fetch (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_ack      (wb_ack),
        .wb_dat      (wb_dat),
        .hold        (stall),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt)
    );

    // fetch/decode holds its word while decode stalls
    pipe_reg #(.payload_t(fetch_pkt_t)) u_fd_reg (
        .clk       (clk),
        .rst       (rst),
        .hold      (stall),
        .bubble    (1'b0),
        .in_valid  (fetch_valid),
        .in_data   (fetch_pkt),
        .out_valid (fd_valid),
        .out_data  (fd_pkt)
    );

    //////////////////////////////
    // decode
    //////////////////////////////

    decoder u_dec (
        .fetch_pkt  (fd_pkt),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .decode_pkt (decode_pkt)
    );

    // read in decode, written from the writeback register
    regfile u_rf (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr_en   (commit_valid),
        .wr_idx  (commit_rd),
        .wr_data (commit_data)
    );

    // no forwarding, every raw hazard waits for writeback
    hazard_scoreboard u_sb (
        .clk          (clk),
        .rst          (rst),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .issue_valid  (fd_valid),
        .issue_rd     (decode_pkt.rd),
        .retire_valid (commit_valid),
        .retire_rd    (commit_rd),
        .stall        (stall)
    );

    // decode/execute takes a bubble on stall
    pipe_reg #(.payload_t(decode_pkt_t)) u_de_reg (
        .clk       (clk),
        .rst       (rst),
        .hold      (1'b0),
        .bubble    (stall),
        .in_valid  (fd_valid),
        .in_data   (decode_pkt),
        .out_valid (de_valid),
        .out_data  (de_pkt)
    );

    //////////////////////////////
    // execute and writeback
    //////////////////////////////

    alu u_alu (
        .decode_pkt (de_pkt),
        .wb_pkt     (ex_pkt)
    );

    pipe_reg #(.payload_t(wb_pkt_t)) u_ew_reg (
        .clk       (clk),
        .rst       (rst),
        .hold      (1'b0),
        .bubble    (1'b0),
        .in_valid  (de_valid),
        .in_data   (ex_pkt),
        .out_valid (ew_valid),
        .out_data  (ew_pkt)
    );

    // retire only instructions that write a register
    assign commit_valid = ew_valid && ew_pkt.wr_en;
    assign commit_rd    = ew_pkt.rd;
    assign commit_data  = ew_pkt.data;

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
// pipeline stage register with valid bit, hold and bubble insertion
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           hold,
    input  wire           bubble,
    input  wire           in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    // valid is control state
    // hold keeps the stage occupied, bubble loads an empty slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid && !bubble;
        end
    end

    // payload only meaningful while valid
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// integer register file, two combinational reads and one synchronous write
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire core_pkg::reg_idx_t rs1_idx,
    input  wire core_pkg::reg_idx_t rs2_idx,
    output core_pkg::xlen_t         rs1_val,
    output core_pkg::xlen_t         rs2_val,
    input  wire                     wr_en,
    input  wire core_pkg::reg_idx_t wr_idx,
    input  wire core_pkg::xlen_t    wr_data
);

    import core_pkg::*;

    xlen_t regs [`CORE_REG_COUNT];

    // x0 reads as zero whatever the array holds
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // written at the end of the writeback cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module core_tb -Mdir obj_dir -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vcore_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// ==== tests/core_tb.sv ====
// testbench for the four-stage core: instruction table, wishbone memory model, commit checker
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_tb;

    import core_pkg::*;

    //////////////////////////////
    // table and limits
    //////////////////////////////

    localparam int NUM_ROWS        = 25;
    // words fetched past the table before the final drain check
    localparam int DRAIN_WORDS     = 8;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40;

    // rv32i opcodes and function fields
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    logic     clk = 1'b0;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    xlen_t    wb_adr;
    logic     wb_ack;
    xlen_t    wb_dat;
    logic     commit_valid;
    reg_idx_t commit_rd;
    xlen_t    commit_data;

    // one row per instruction word, in program order
    string    row_name   [NUM_ROWS];
    xlen_t    row_inst   [NUM_ROWS];
    logic     row_commit [NUM_ROWS];
    reg_idx_t row_rd     [NUM_ROWS];
    xlen_t    row_val    [NUM_ROWS];
    int       row_count = 0;

    // memory model state
    integer     seed = 32'h527c;
    logic [31:0] rnd;
    logic [1:0] wait_left;
    logic       req_open;
    xlen_t      expected_adr;
    int         acked_words = 0;

    // observed commits, oldest first
    reg_idx_t commit_rd_q [$];
    xlen_t    commit_data_q [$];

    int check_count = 0;
    int err_count   = 0;

    core_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .wb_dat       (wb_dat),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    // 4 ns period
    always #2 clk = ~clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_logic(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    //////////////////////////////
    // instruction encoders
    //////////////////////////////

    function automatic xlen_t enc_r(input logic [6:0] funct7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] funct3,
                                    input reg_idx_t rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] funct3, input reg_idx_t rd,
                                    input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic xlen_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic add_row(input string name, input xlen_t inst, input logic commit,
                           input reg_idx_t rd, input xlen_t val);
        row_name[row_count]   = name;
        row_inst[row_count]   = inst;
        row_commit[row_count] = commit;
        row_rd[row_count]     = rd;
        row_val[row_count]    = val;
        row_count++;
    endtask

    // expected values worked out by hand, registers start at zero
    task automatic load_program();
        // independent operations
        add_row("addi_x1", enc_i(12'h005, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), 1'b1, 5'd1, 32'h5);
        add_row("addi_neg_x2", enc_i(12'hFFD, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM), 1'b1, 5'd2,
                32'hFFFF_FFFD);
        add_row("lui_x3", enc_u(20'h12345, 5'd3), 1'b1, 5'd3, 32'h1234_5000);
        add_row("addi_x4", enc_i(12'h5A6, 5'd0, F3_ADD, 5'd4, OPC_OP_IMM), 1'b1, 5'd4,
                32'h0000_05A6);
        add_row("add_x5", enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd5), 1'b1, 5'd5, 32'h2);
        add_row("sub_x6", enc_r(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd6), 1'b1, 5'd6, 32'h8);
        add_row("and_x7", enc_r(F7_BASE, 5'd4, 5'd2, F3_AND, 5'd7), 1'b1, 5'd7, 32'h5A4);
        add_row("or_x8", enc_r(F7_BASE, 5'd1, 5'd4, F3_OR, 5'd8), 1'b1, 5'd8, 32'h5A7);
        add_row("xor_x9", enc_r(F7_BASE, 5'd4, 5'd2, F3_XOR, 5'd9), 1'b1, 5'd9, 32'hFFFF_FA5B);
        // chain, each row reads the previous destination
        add_row("chain_addi_x10", enc_i(12'h001, 5'd0, F3_ADD, 5'd10, OPC_OP_IMM), 1'b1, 5'd10,
                32'h1);
        add_row("chain_addi_x10_again", enc_i(12'h002, 5'd10, F3_ADD, 5'd10, OPC_OP_IMM), 1'b1,
                5'd10, 32'h3);
        add_row("chain_add_x11", enc_r(F7_BASE, 5'd10, 5'd10, F3_ADD, 5'd11), 1'b1, 5'd11, 32'h6);
        add_row("chain_sub_x12", enc_r(F7_SUB, 5'd10, 5'd11, F3_ADD, 5'd12), 1'b1, 5'd12, 32'h3);
        add_row("chain_xor_x12", enc_r(F7_BASE, 5'd11, 5'd12, F3_XOR, 5'd12), 1'b1, 5'd12, 32'h5);
        add_row("chain_lui_x13", enc_u(20'hABCDE, 5'd13), 1'b1, 5'd13, 32'hABCD_E000);
        add_row("chain_addi_x13", enc_i(12'hFFF, 5'd13, F3_ADD, 5'd13, OPC_OP_IMM), 1'b1, 5'd13,
                32'hABCD_DFFF);
        // no commit expected from these five
        add_row("addi_to_x0", enc_i(12'h007, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM), 1'b0, 5'd0, 32'h0);
        add_row("add_to_x0", enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row("sll_unsupported", enc_r(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd14), 1'b0, 5'd0, 32'h0);
        add_row("lw_unsupported", enc_i(12'h000, 5'd1, F3_LW, 5'd14, OPC_LOAD), 1'b0, 5'd0,
                32'h0);
        add_row("ori_unsupported", enc_i(12'h0F0, 5'd1, F3_OR, 5'd18, OPC_OP_IMM), 1'b0, 5'd0,
                32'h0);
        // x0 reads zero, skipped destinations stay zero
        add_row("or_x0_x1", enc_r(F7_BASE, 5'd1, 5'd0, F3_OR, 5'd15), 1'b1, 5'd15, 32'h5);
        add_row("add_x14_x0", enc_r(F7_BASE, 5'd0, 5'd14, F3_ADD, 5'd16), 1'b1, 5'd16, 32'h0);
        add_row("add_x18_x1", enc_r(F7_BASE, 5'd1, 5'd18, F3_ADD, 5'd19), 1'b1, 5'd19, 32'h5);
        add_row("sub_x13_x0", enc_r(F7_SUB, 5'd0, 5'd13, F3_ADD, 5'd20), 1'b1, 5'd20,
                32'hABCD_DFFF);
    endtask

    // table word, nop beyond it
    function automatic xlen_t fetch_word(input xlen_t adr);
        int word_idx;
        word_idx = adr >> 2;
        if (word_idx < NUM_ROWS) begin
            return row_inst[word_idx];
        end
        return `CORE_NOP;
    endfunction

    //////////////////////////////
    // wishbone memory model
    //////////////////////////////

    // 0 to 3 wait cycles per request, ack lasts one cycle
    always @(negedge clk) begin
        if (rst) begin
            wb_ack   = 1'b0;
            req_open = 1'b0;
        end else begin
            if (wb_cyc !== wb_stb) begin
                note_failure("wishbone cyc and stb differ");
            end
            if (wb_ack) begin
                // taken at the last rising edge
                wb_ack = 1'b0;
            end else if (wb_cyc) begin
                check_xlen("fetch address", expected_adr, wb_adr);
                if (!req_open) begin
                    req_open  = 1'b1;
                    rnd       = $random(seed);
                    wait_left = rnd[1:0];
                end
                if (wait_left == 2'd0) begin
                    wb_dat       = fetch_word(wb_adr);
                    wb_ack       = 1'b1;
                    req_open     = 1'b0;
                    expected_adr = expected_adr + 32'd4;
                    acked_words++;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    // commit monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && commit_valid === 1'b1) begin
            if (commit_rd == '0) begin
                note_failure("commit to register zero");
            end
            commit_rd_q.push_back(commit_rd);
            commit_data_q.push_back(commit_data);
        end
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no end of run after %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, err_count + 1);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        reg_idx_t got_rd;
        xlen_t    got_data;

        rst          = 1'b1;
        wb_ack       = 1'b0;
        wb_dat       = `CORE_NOP;
        req_open     = 1'b0;
        wait_left    = 2'd0;
        expected_adr = `CORE_RESET_PC;
        load_program();
        if (row_count != NUM_ROWS) begin
            note_failure("instruction table row count does not match its size");
        end

        // bus and commit quiet through reset
        repeat (3) begin
            @(negedge clk);
            check_logic("reset wb_cyc", 1'b0, wb_cyc);
            check_logic("reset wb_stb", 1'b0, wb_stb);
            check_logic("reset commit_valid", 1'b0, commit_valid);
        end
        rst = 1'b0;

        @(negedge clk);
        check_logic("after reset commit_valid", 1'b0, commit_valid);
        // first request opens whenever the master is ready
        while (wb_cyc !== 1'b1) begin
            @(negedge clk);
        end
        check_xlen("first request address", `CORE_RESET_PC, wb_adr);

        // each expected commit against the next observed one
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_commit[r]) begin
                while (commit_rd_q.size() == 0) begin
                    @(posedge clk);
                end
                got_rd   = commit_rd_q.pop_front();
                got_data = commit_data_q.pop_front();
                check_reg_idx(row_name[r], row_rd[r], got_rd);
                check_xlen(row_name[r], row_val[r], got_data);
            end
        end

        // nops past the table push the last rows out
        while (acked_words < NUM_ROWS + DRAIN_WORDS) begin
            @(posedge clk);
        end
        if (commit_rd_q.size() != 0) begin
            note_failure($sformatf("%0d unexpected commits after the table",
                                   commit_rd_q.size()));
        end

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
